// File: ConfigChecker.sv
`timescale 1ns/100ps

module ConfigChecker
	import MicrorocPkg::*;
#(
	parameter int NameBits = 224
)
(
	input  logic                         Clk,
	input  logic                         reset_n,
	input  logic                         SerialData,
	input  logic                         SerialStrobe,
	input  logic                         ConfigDone,
	input  logic                         Busy,
	input  logic                         Arm,            // Load expectation valid
	input  logic                         IdleDone,       // End of a quiet window
	input  logic [SlowControlLength-1:0] ExpectedImage,
	input  int                           ExpectedLength,
	input  logic [NameBits-1:0]          TestName,
	output int                           PassCount,
	output int                           FailCount,
	output int                           ResultCount
);

	logic [SlowControlLength-1:0] Collected;  // Serial bits, last one in LSB
	logic [SlowControlLength-1:0] Mask;
	logic                         Armed;
	logic                         SeenBusy;
	logic                         BusyDropped;
	logic                         LoadOk;
	int                           BitCount;
	int                           StrayCount; // Cycles of activity with no load

	assign Mask = {SlowControlLength{1'b1}} >> (SlowControlLength - ExpectedLength);

	// Packed name to text, leading pad bytes dropped
	function automatic string NameText(input logic [NameBits-1:0] Packed);
		string      Text;
		logic [7:0] Char;
		Text = "";
		for (int i = NameBits / 8 - 1; i >= 0; i--) begin
			Char = Packed[i*8 +: 8];
			if (Char != 8'd0)
				Text = {Text, $sformatf("%c", Char)};
		end
		return Text;
	endfunction

	task automatic Tally(input logic Ok);
		if (Ok)
			PassCount++;
		else
			FailCount++;
		ResultCount++; // Testbench waits on this
	endtask

	//////////////////////////////////////////////////
	// Serial capture and compare
	//////////////////////////////////////////////////

	always @(posedge Clk) begin
		if (!reset_n) begin
			Armed       = 1'b0;
			SeenBusy    = 1'b0;
			BusyDropped = 1'b0;
			Collected   = '0;
			BitCount    = 0;
			StrayCount  = 0;
			PassCount   = 0;
			FailCount   = 0;
			ResultCount = 0;
		end else if (Armed) begin
			if (Busy)
				SeenBusy = 1'b1;
			else if (SeenBusy && !ConfigDone)
				BusyDropped = 1'b1; // Busy fell early
			if (SerialStrobe) begin
				Collected = {Collected[SlowControlLength-2:0], SerialData}; // MSB first
				BitCount++;
			end
			if (ConfigDone) begin
				LoadOk = !BusyDropped;
				if (BitCount != ExpectedLength) begin
					$display("[FAIL] %0s: expected %0d bits, actual %0d bits",
						NameText(TestName), ExpectedLength, BitCount);
					LoadOk = 1'b0;
				end
				if ((Collected & Mask) != (ExpectedImage & Mask)) begin
					$display("[FAIL] %0s: expected %h, actual %h", NameText(TestName),
						ExpectedImage & Mask, Collected & Mask);
					LoadOk = 1'b0;
				end
				if (BusyDropped)
					$display("%0s failed because Busy went low before ConfigDone",
						NameText(TestName));
				if (LoadOk)
					$display("[PASS] %0s: %0d bits", NameText(TestName), BitCount);
				Tally(LoadOk);
				Armed = 1'b0;
			end
		end else begin
			if (SerialStrobe || ConfigDone || Busy) begin
				if (StrayCount == 0)
					$display("Serial activity or Busy seen with no load pending");
				StrayCount++;
			end
			if (IdleDone) begin
				if (StrayCount == 0)
					$display("[PASS] %0s: outputs quiet", NameText(TestName));
				else
					$display("[FAIL] %0s: expected 0 active cycles, actual %0d",
						NameText(TestName), StrayCount);
				Tally(StrayCount == 0);
				StrayCount = 0;
			end
			if (Arm) begin
				Armed       = 1'b1; // Start sampled on this same edge
				SeenBusy    = 1'b0;
				BusyDropped = 1'b0;
				Collected   = '0;
				BitCount    = 0;
			end
		end
	end

endmodule

// File: ConfigTb.sv
`timescale 1ns/100ps

module ConfigTb
	import MicrorocPkg::*;
;

	localparam int NameBits      = 8 * 28; // Packed test name, eight bits per char
	localparam int PoolWords     = (SlowControlLength + 31) / 32;
	localparam int TestCount     = 8;      // Load tests plus idle windows
	localparam int TotalBits     = 3 * SlowControlLength + 2 * ReadScopeLength;
	localparam int TimeoutCycles = 2 * (TotalBits * 10 + 200 * TestCount);
	localparam int IdleWindow    = 200;    // Quiet cycles after a load

	logic         Clk;
	logic         reset_n;
	logic         SlowClock;
	logic         SlowControlOrReadScopeSelect;
	logic         ParameterLoadStart;
	logic [1:0]   DataoutChannelSelect;
	logic [1:0]   TransmitOnChannelSelect;
	logic         ChipSatbEnable;
	logic         StartReadoutChannelSelect;
	logic         EndReadoutChannelSelect;
	logic [1:0]   NC;
	logic [1:0]   InternalRazSignalLength;
	logic         CkMux;
	logic         LvdsReceiverPPEnable;
	logic         ExternalRazSignalEnable;
	logic         InternalRazSignalEnable;
	logic         ExternalTriggerEnable;
	logic         TriggerNor64OrDirectSelect;
	logic         TriggerOutputEnable;
	logic [2:0]   TriggerToWriteSelect;
	logic [9:0]   Dac2Vth;
	logic [9:0]   Dac1Vth;
	logic [9:0]   Dac0Vth;
	logic         DacEnable;
	logic         DacPPEnable;
	logic         BandGapEnable;
	logic         BandGapPPEnable;
	logic [7:0]   ChipID;
	logic [191:0] ChannelDiscriminatorMask;
	logic         LatchedOrDirectOutput;
	logic         Discriminator1PPEnable;
	logic         Discriminator2PPEnable;
	logic         Discriminator0PPEnable;
	logic         OTAqPPEnable;
	logic         OTAqEnable;
	logic         Dac4bitPPEnable;
	logic [255:0] ChannelAdjust;
	logic [1:0]   HighGainShaperFeedbackSelect;
	logic         ShaperOutLowGainOrHighGain;
	logic         WidlarPPEnable;
	logic [1:0]   LowGainShaperFeedbackSelect;
	logic         LowGainShaperPPEnable;
	logic         HighGainShaperPPEnable;
	logic         GainBoostEnable;
	logic         PreAmplifierPPEnable;
	logic [63:0]  CTestChannel;
	logic [63:0]  ReadScopeChannel;
	logic         SerialData;
	logic         SerialStrobe;
	logic         ConfigDone;
	logic         Busy;

	logic                         Arm;           // Expectation handed to checker
	logic                         IdleDone;      // Closes a quiet window
	logic [SlowControlLength-1:0] ExpectedImage; // Right aligned
	int                           ExpectedLength;
	logic [NameBits-1:0]          TestName;
	int                           PassCount;
	int                           FailCount;
	int                           ResultCount;
	int                           CycleCount;

	MicrorocConfigTop #(
		.FifoDepth (64)
	) DUT (.*);

	ConfigChecker #(
		.NameBits (NameBits)
	) Checker (
		.Clk            (Clk),
		.reset_n        (reset_n),
		.SerialData     (SerialData),
		.SerialStrobe   (SerialStrobe),
		.ConfigDone     (ConfigDone),
		.Busy           (Busy),
		.Arm            (Arm),
		.IdleDone       (IdleDone),
		.ExpectedImage  (ExpectedImage),
		.ExpectedLength (ExpectedLength),
		.TestName       (TestName),
		.PassCount      (PassCount),
		.FailCount      (FailCount),
		.ResultCount    (ResultCount)
	);

	//////////////////////////////////////////////////
	// Clocks and run limit
	//////////////////////////////////////////////////

	initial begin
		Clk = 1'b0;
		forever #2 Clk = ~Clk; // 4 ns period
	end

	initial begin
		SlowClock = 1'b0;
		forever begin
			repeat (5) @(negedge Clk);
			SlowClock = ~SlowClock; // Ten Clk cycles per slow period
		end
	end

	initial begin
		CycleCount = 0;
		while (CycleCount < TimeoutCycles) begin
			@(posedge Clk);
			CycleCount++;
		end
		$display("Run timed out after %0d cycles without finishing", CycleCount);
		$display("Checks failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Reference model and stimulus helpers
	//////////////////////////////////////////////////

	// Chip bit order, first field leaves first
	function automatic logic [SlowControlLength-1:0] ReferenceImage(input logic ReadScope);
		if (ReadScope)
			return {{(SlowControlLength - ReadScopeLength){1'b0}}, ReadScopeChannel};
		return {DataoutChannelSelect, TransmitOnChannelSelect, ChipSatbEnable,
			StartReadoutChannelSelect, EndReadoutChannelSelect, NC,
			InternalRazSignalLength, CkMux, LvdsReceiverPPEnable,
			ExternalRazSignalEnable, InternalRazSignalEnable, ExternalTriggerEnable,
			TriggerNor64OrDirectSelect, TriggerOutputEnable, TriggerToWriteSelect,
			Dac2Vth, Dac1Vth, Dac0Vth, DacEnable, DacPPEnable, BandGapEnable,
			BandGapPPEnable, ChipID, ChannelDiscriminatorMask,
			LatchedOrDirectOutput, Discriminator1PPEnable, Discriminator2PPEnable,
			Discriminator0PPEnable, OTAqPPEnable, OTAqEnable, Dac4bitPPEnable,
			ChannelAdjust, HighGainShaperFeedbackSelect, ShaperOutLowGainOrHighGain,
			WidlarPPEnable, LowGainShaperFeedbackSelect, LowGainShaperPPEnable,
			HighGainShaperPPEnable, GainBoostEnable, PreAmplifierPPEnable,
			CTestChannel};
	endfunction

	task automatic FillFields();
		logic [PoolWords*32-1:0] Pool;
		for (int i = 0; i < PoolWords; i++)
			Pool[i*32 +: 32] = $urandom;
		{CTestChannel, ChannelAdjust, ChannelDiscriminatorMask, ChipID, Dac0Vth, Dac1Vth,
			Dac2Vth, DataoutChannelSelect, TransmitOnChannelSelect, ChipSatbEnable,
			StartReadoutChannelSelect, EndReadoutChannelSelect, NC, InternalRazSignalLength,
			CkMux, LvdsReceiverPPEnable, ExternalRazSignalEnable, InternalRazSignalEnable,
			ExternalTriggerEnable, TriggerNor64OrDirectSelect, TriggerOutputEnable,
			TriggerToWriteSelect, DacEnable, DacPPEnable, BandGapEnable, BandGapPPEnable,
			LatchedOrDirectOutput, Discriminator1PPEnable, Discriminator2PPEnable,
			Discriminator0PPEnable, OTAqPPEnable, OTAqEnable, Dac4bitPPEnable,
			HighGainShaperFeedbackSelect, ShaperOutLowGainOrHighGain, WidlarPPEnable,
			LowGainShaperFeedbackSelect, LowGainShaperPPEnable, HighGainShaperPPEnable,
			GainBoostEnable, PreAmplifierPPEnable} = Pool[SlowControlLength-1:0];
		ReadScopeChannel = {$urandom, $urandom};
	endtask

	task automatic WaitForResult(input int Target);
		while (ResultCount < Target)
			@(negedge Clk); // Run limit guards this loop
	endtask

	// Arms checker and pulses start together
	task automatic StartLoad(input logic Select, input logic [NameBits-1:0] Name);
		SlowControlOrReadScopeSelect = Select;
		ExpectedImage      = ReferenceImage(Select);
		ExpectedLength     = Select ? ReadScopeLength : SlowControlLength;
		TestName           = Name;
		Arm                = 1'b1;
		ParameterLoadStart = 1'b1;
		@(negedge Clk);
		Arm                = 1'b0;
		ParameterLoadStart = 1'b0;
	endtask

	task automatic RunLoad(input logic Select, input logic [NameBits-1:0] Name);
		int Target;
		Target = ResultCount + 1;
		StartLoad(Select, Name);
		WaitForResult(Target);
	endtask

	task automatic FinishIdle(input int Cycles, input logic [NameBits-1:0] Name);
		int Target;
		repeat (Cycles) @(negedge Clk);
		Target   = ResultCount + 1;
		TestName = Name;
		IdleDone = 1'b1;
		@(negedge Clk);
		IdleDone = 1'b0;
		WaitForResult(Target);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		int Target;
		reset_n                      = 1'b0;
		SlowControlOrReadScopeSelect = 1'b0;
		ParameterLoadStart           = 1'b0;
		Arm                          = 1'b0;
		IdleDone                     = 1'b0;
		ExpectedImage                = '0;
		ExpectedLength               = 0;
		TestName                     = '0;
		void'($urandom(32'he473e29c)); // One seed for the whole run
		FillFields();
		repeat (10) @(negedge Clk);
		reset_n = 1'b1;

		FinishIdle(50, NameBits'("idle after reset"));    // Nothing moves before a start

		FillFields();
		RunLoad(1'b0, NameBits'("slow control load"));
		FillFields();
		RunLoad(1'b1, NameBits'("read scope load"));

		// Second start lands mid-shift and must vanish
		FillFields();
		Target = ResultCount + 1;
		StartLoad(1'b0, NameBits'("start while busy"));
		repeat (100) @(negedge Clk);
		SlowControlOrReadScopeSelect = 1'b1;
		ParameterLoadStart           = 1'b1;
		@(negedge Clk);
		ParameterLoadStart = 1'b0;
		WaitForResult(Target);
		FinishIdle(IdleWindow, NameBits'("no second image"));

		FillFields();
		RunLoad(1'b0, NameBits'("back to back slow control"));
		FillFields();
		RunLoad(1'b1, NameBits'("back to back read scope")); // Started right after done
		FinishIdle(IdleWindow, NameBits'("no leftover words"));

		$display("Tests run %0d, passed %0d, failed %0d", ResultCount, PassCount, FailCount);
		if (FailCount == 0 && PassCount == TestCount)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = ConfigTb
FILELIST  = list.f
OBJDIR    = obj_dir
PASS_MSG  = All checks passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// File: MicrorocConfigTop.sv
`timescale 1ns/100ps

module MicrorocConfigTop
	import MicrorocPkg::*;
#(
	parameter int FifoDepth = 64 // Must hold a full slow-control image
)
(
	input  logic         Clk,
	input  logic         reset_n,
	input  logic         SlowClock,
	input  logic         SlowControlOrReadScopeSelect,
	input  logic         ParameterLoadStart,
	input  logic [1:0]   DataoutChannelSelect,
	input  logic [1:0]   TransmitOnChannelSelect,
	input  logic         ChipSatbEnable,
	input  logic         StartReadoutChannelSelect,
	input  logic         EndReadoutChannelSelect,
	input  logic [1:0]   NC,
	input  logic [1:0]   InternalRazSignalLength,
	input  logic         CkMux,
	input  logic         LvdsReceiverPPEnable,
	input  logic         ExternalRazSignalEnable,
	input  logic         InternalRazSignalEnable,
	input  logic         ExternalTriggerEnable,
	input  logic         TriggerNor64OrDirectSelect,
	input  logic         TriggerOutputEnable,
	input  logic [2:0]   TriggerToWriteSelect,
	input  logic [9:0]   Dac2Vth,
	input  logic [9:0]   Dac1Vth,
	input  logic [9:0]   Dac0Vth,
	input  logic         DacEnable,
	input  logic         DacPPEnable,
	input  logic         BandGapEnable,
	input  logic         BandGapPPEnable,
	input  logic [7:0]   ChipID,
	input  logic [191:0] ChannelDiscriminatorMask,
	input  logic         LatchedOrDirectOutput,
	input  logic         Discriminator1PPEnable,
	input  logic         Discriminator2PPEnable,
	input  logic         Discriminator0PPEnable,
	input  logic         OTAqPPEnable,
	input  logic         OTAqEnable,
	input  logic         Dac4bitPPEnable,
	input  logic [255:0] ChannelAdjust,
	input  logic [1:0]   HighGainShaperFeedbackSelect,
	input  logic         ShaperOutLowGainOrHighGain,
	input  logic         WidlarPPEnable,
	input  logic [1:0]   LowGainShaperFeedbackSelect,
	input  logic         LowGainShaperPPEnable,
	input  logic         HighGainShaperPPEnable,
	input  logic         GainBoostEnable,
	input  logic         PreAmplifierPPEnable,
	input  logic [63:0]  CTestChannel,
	input  logic [63:0]  ReadScopeChannel,
	output logic         SerialData,   // To chip serial input
	output logic         SerialStrobe, // One pulse per bit
	output logic         ConfigDone,
	output logic         Busy
);

	logic                 FifoWriteEn;
	logic [WordWidth-1:0] FifoWriteData;
	logic                 FifoReadEn;
	logic [WordWidth-1:0] FifoReadData;
	logic                 FifoEmpty;
	logic                 ParameterDone;
	logic                 GeneratorBusy;
	logic                 ShifterBusy;

	//////////////////////////////////////////////////
	// Generator to FIFO to shifter chain
	//////////////////////////////////////////////////

	ParameterGenerator Generator (.*); // Field ports share names with the top

	ParameterFifo #(
		.FifoDepth (FifoDepth)
	) Fifo (
		.Clk       (Clk),
		.reset_n   (reset_n),
		.WriteEn   (FifoWriteEn),
		.WriteData (FifoWriteData),
		.ReadEn    (FifoReadEn),
		.ReadData  (FifoReadData),
		.Empty     (FifoEmpty),
		.Full      ()             // Depth covers the largest image
	);

	SerialShifter Shifter (.*);

	assign Busy = GeneratorBusy || ShifterBusy; // Accepted start until ConfigDone

endmodule

// File: MicrorocPkg.sv
package MicrorocPkg;

	//////////////////////////////////////////////////
	// Register image geometry
	//////////////////////////////////////////////////

	localparam int unsigned WordWidth         = 16;  // FIFO word and shifter word
	localparam int unsigned SlowControlLength = 592; // Full slow-control image in bits
	localparam int unsigned ReadScopeLength   = 64;  // One mask bit per channel

	// Word counts per image, rounded up to whole FIFO words
	localparam int unsigned SlowControlWords =
		(SlowControlLength + WordWidth - 1) / WordWidth; // 37 words
	localparam int unsigned ReadScopeWords =
		(ReadScopeLength + WordWidth - 1) / WordWidth;   // 4 words

endpackage

// File: ParameterFifo.sv
`timescale 1ns/100ps

module ParameterFifo
	import MicrorocPkg::*;
#(
	parameter int FifoDepth = 64
)
(
	input  logic                 Clk,
	input  logic                 reset_n,
	input  logic                 WriteEn,
	input  logic [WordWidth-1:0] WriteData,
	input  logic                 ReadEn,
	output logic [WordWidth-1:0] ReadData,
	output logic                 Empty,
	output logic                 Full
);

	localparam int PtrWidth   = $clog2(FifoDepth);
	localparam int CountWidth = $clog2(FifoDepth + 1);
	localparam logic [PtrWidth-1:0]   LastPtr   = PtrWidth'(FifoDepth - 1);
	localparam logic [CountWidth-1:0] FullCount = CountWidth'(FifoDepth);

	logic [WordWidth-1:0]  Memory [FifoDepth];
	logic [PtrWidth-1:0]   WritePtr;
	logic [PtrWidth-1:0]   ReadPtr;
	logic [CountWidth-1:0] Count;    // Occupancy
	logic                  DoWrite;
	logic                  DoRead;

	assign DoWrite  = WriteEn && !Full;  // Overflow dropped
	assign DoRead   = ReadEn && !Empty;  // Underflow ignored
	assign Empty    = (Count == '0);
	assign Full     = (Count == FullCount);
	assign ReadData = Memory[ReadPtr];   // Head word falls through

	always_ff @(posedge Clk) begin
		if (DoWrite)
			Memory[WritePtr] <= WriteData;
	end

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			WritePtr <= '0;
			ReadPtr  <= '0;
			Count    <= '0;
		end else begin
			if (DoWrite)
				WritePtr <= (WritePtr == LastPtr) ? '0 : WritePtr + 1'b1; // Wrap for any depth
			if (DoRead)
				ReadPtr <= (ReadPtr == LastPtr) ? '0 : ReadPtr + 1'b1;
			if (DoWrite && !DoRead)
				Count <= Count + 1'b1;
			else if (DoRead && !DoWrite)
				Count <= Count - 1'b1;
		end
	end

endmodule

// File: ParameterGenerator.sv
`timescale 1ns/100ps

module ParameterGenerator
	import MicrorocPkg::*;
(
	input  logic                 Clk,
	input  logic                 reset_n,
	input  logic                 SlowControlOrReadScopeSelect, // High picks read scope
	input  logic                 ParameterLoadStart,
	input  logic                 ShifterBusy,
	// Slow-control fields from the image MSB down
	input  logic [1:0]           DataoutChannelSelect,
	input  logic [1:0]           TransmitOnChannelSelect,
	input  logic                 ChipSatbEnable,
	input  logic                 StartReadoutChannelSelect,
	input  logic                 EndReadoutChannelSelect,
	input  logic [1:0]           NC,                        // Unused bits inside the chip
	input  logic [1:0]           InternalRazSignalLength,   // 75ns up to 1us
	input  logic                 CkMux,                     // Bypass power-on digital
	input  logic                 LvdsReceiverPPEnable,
	input  logic                 ExternalRazSignalEnable,
	input  logic                 InternalRazSignalEnable,
	input  logic                 ExternalTriggerEnable,
	input  logic                 TriggerNor64OrDirectSelect,
	input  logic                 TriggerOutputEnable,
	input  logic [2:0]           TriggerToWriteSelect,
	input  logic [9:0]           Dac2Vth,
	input  logic [9:0]           Dac1Vth,
	input  logic [9:0]           Dac0Vth,
	input  logic                 DacEnable,
	input  logic                 DacPPEnable,
	input  logic                 BandGapEnable,
	input  logic                 BandGapPPEnable,
	input  logic [7:0]           ChipID,
	input  logic [191:0]         ChannelDiscriminatorMask,  // Three bits per channel
	input  logic                 LatchedOrDirectOutput,
	input  logic                 Discriminator1PPEnable,
	input  logic                 Discriminator2PPEnable,
	input  logic                 Discriminator0PPEnable,
	input  logic                 OTAqPPEnable,
	input  logic                 OTAqEnable,
	input  logic                 Dac4bitPPEnable,
	input  logic [255:0]         ChannelAdjust,             // Four bits per channel
	input  logic [1:0]           HighGainShaperFeedbackSelect,
	input  logic                 ShaperOutLowGainOrHighGain,
	input  logic                 WidlarPPEnable,
	input  logic [1:0]           LowGainShaperFeedbackSelect,
	input  logic                 LowGainShaperPPEnable,
	input  logic                 HighGainShaperPPEnable,
	input  logic                 GainBoostEnable,
	input  logic                 PreAmplifierPPEnable,
	input  logic [63:0]          CTestChannel,              // Test capacitor per channel
	input  logic [63:0]          ReadScopeChannel,
	output logic                 FifoWriteEn,
	output logic [WordWidth-1:0] FifoWriteData,
	output logic                 ParameterDone,
	output logic                 GeneratorBusy
);

	localparam logic [2:0] GenIdle    = 3'd0;
	localparam logic [2:0] GenRsWrite = 3'd1; // Read-scope loop
	localparam logic [2:0] GenRsShift = 3'd2;
	localparam logic [2:0] GenScWrite = 3'd3; // Slow-control loop
	localparam logic [2:0] GenScShift = 3'd4;
	localparam logic [2:0] GenEnd     = 3'd5;

	localparam logic [5:0] ScLastWord = 6'(SlowControlWords - 1);
	localparam logic [5:0] RsLastWord = 6'(ReadScopeWords - 1);

	logic [SlowControlLength-1:0] SlowControlImage;
	logic [SlowControlLength-1:0] SlowControlShift;
	logic [ReadScopeLength-1:0]   ReadScopeShift;
	logic [5:0]                   WordCount;
	logic [2:0]                   CurrentState;
	logic [2:0]                   NextState;
	logic                         StartAccepted;

	//////////////////////////////////////////////////
	// Slow-control image in chip bit order
	//////////////////////////////////////////////////

	assign SlowControlImage = {
		DataoutChannelSelect, TransmitOnChannelSelect, ChipSatbEnable,   // Output enables
		StartReadoutChannelSelect, EndReadoutChannelSelect, NC,
		InternalRazSignalLength, CkMux, LvdsReceiverPPEnable,
		ExternalRazSignalEnable, InternalRazSignalEnable,                 // Trigger cell
		ExternalTriggerEnable, TriggerNor64OrDirectSelect,
		TriggerOutputEnable, TriggerToWriteSelect,
		Dac2Vth, Dac1Vth, Dac0Vth,                                        // Triple DAC
		DacEnable, DacPPEnable, BandGapEnable, BandGapPPEnable,
		ChipID,
		ChannelDiscriminatorMask,
		LatchedOrDirectOutput, Discriminator1PPEnable,                    // Bias block
		Discriminator2PPEnable, Discriminator0PPEnable,
		OTAqPPEnable, OTAqEnable, Dac4bitPPEnable,
		ChannelAdjust,
		HighGainShaperFeedbackSelect, ShaperOutLowGainOrHighGain,         // Shapers
		WidlarPPEnable, LowGainShaperFeedbackSelect,
		LowGainShaperPPEnable, HighGainShaperPPEnable,
		GainBoostEnable, PreAmplifierPPEnable,
		CTestChannel                                                      // Lands in LSBs
	};

	//////////////////////////////////////////////////
	// Load FSM
	//////////////////////////////////////////////////

	assign StartAccepted = ParameterLoadStart && !ShifterBusy; // Busy starts are dropped
	assign GeneratorBusy = (CurrentState != GenIdle);

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n)
			CurrentState <= GenIdle;
		else
			CurrentState <= NextState;
	end

	always_comb begin
		NextState = CurrentState;
		case (CurrentState)
			GenIdle: begin
				if (StartAccepted)
					NextState = SlowControlOrReadScopeSelect ? GenRsWrite : GenScWrite;
			end
			GenRsWrite: NextState = GenRsShift;
			GenRsShift: NextState = (WordCount == RsLastWord) ? GenEnd : GenRsWrite;
			GenScWrite: NextState = GenScShift;
			GenScShift: NextState = (WordCount == ScLastWord) ? GenEnd : GenScWrite;
			GenEnd:     NextState = GenIdle;
			default:    NextState = GenIdle;
		endcase
	end

	// Strobes and word counter
	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			FifoWriteEn   <= 1'b0;
			ParameterDone <= 1'b0;
			WordCount     <= 6'd0;
		end else begin
			FifoWriteEn   <= 1'b0; // Single-cycle strobes
			ParameterDone <= 1'b0;
			case (CurrentState)
				GenIdle:    WordCount <= 6'd0;
				GenRsWrite: FifoWriteEn <= 1'b1;
				GenScWrite: FifoWriteEn <= 1'b1;
				GenRsShift: WordCount <= WordCount + 6'd1;
				GenScShift: WordCount <= WordCount + 6'd1;
				GenEnd:     ParameterDone <= 1'b1; // Every word now sits in the FIFO
				default:    WordCount <= 6'd0;
			endcase
		end
	end

	// Image shift registers and write word
	always_ff @(posedge Clk) begin
		case (CurrentState)
			GenIdle: begin
				SlowControlShift <= SlowControlImage; // Track fields while idle
				ReadScopeShift   <= ReadScopeChannel;
			end
			GenRsWrite: FifoWriteData <= ReadScopeShift[ReadScopeLength-1 -: WordWidth];
			GenRsShift: ReadScopeShift <= ReadScopeShift << WordWidth;
			GenScWrite: FifoWriteData <= SlowControlShift[SlowControlLength-1 -: WordWidth];
			GenScShift: SlowControlShift <= SlowControlShift << WordWidth;
		endcase
	end

endmodule

// File: SerialShifter.sv
`timescale 1ns/100ps

module SerialShifter
	import MicrorocPkg::*;
(
	input  logic                 Clk,
	input  logic                 reset_n,
	input  logic                 SlowClock,     // Chip slow clock, Clk-domain sampled
	input  logic                 ParameterDone,
	input  logic [WordWidth-1:0] FifoReadData,
	input  logic                 FifoEmpty,
	output logic                 FifoReadEn,
	output logic                 SerialData,
	output logic                 SerialStrobe,
	output logic                 ConfigDone,
	output logic                 ShifterBusy
);

	localparam int BitWidth = $clog2(WordWidth);
	localparam logic [BitWidth-1:0] LastBit = BitWidth'(WordWidth - 1);

	localparam logic [1:0] ShIdle   = 2'd0;
	localparam logic [1:0] ShShift  = 2'd1;
	localparam logic [1:0] ShFinish = 2'd2;

	logic [1:0]           SlowSync;  // Two-stage sampler
	logic                 SlowPrev;
	logic                 SlowTick;
	logic [1:0]           State;
	logic [WordWidth-1:0] ShiftReg;
	logic [BitWidth-1:0]  BitCount;
	logic                 WordEnd;

	//////////////////////////////////////////////////
	// Slow clock edge detect
	//////////////////////////////////////////////////

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			SlowSync <= 2'b00;
			SlowPrev <= 1'b0;
		end else begin
			SlowSync <= {SlowSync[0], SlowClock};
			SlowPrev <= SlowSync[1];
		end
	end

	assign SlowTick    = SlowSync[1] && !SlowPrev; // Rising edge
	assign WordEnd     = (BitCount == LastBit);
	assign ShifterBusy = (State != ShIdle) || ParameterDone; // No gap after generator

	//////////////////////////////////////////////////
	// Shift FSM
	//////////////////////////////////////////////////

	always_ff @(posedge Clk or negedge reset_n) begin
		if (!reset_n) begin
			State        <= ShIdle;
			BitCount     <= '0;
			FifoReadEn   <= 1'b0;
			SerialData   <= 1'b0;
			SerialStrobe <= 1'b0;
			ConfigDone   <= 1'b0;
		end else begin
			FifoReadEn   <= 1'b0;
			SerialStrobe <= 1'b0;
			ConfigDone   <= 1'b0;
			case (State)
				ShIdle: begin
					if (ParameterDone) begin
						BitCount <= '0;
						if (FifoEmpty)
							State <= ShFinish; // Nothing queued
						else begin
							FifoReadEn <= 1'b1; // Pop first word
							State      <= ShShift;
						end
					end
				end
				ShShift: begin
					if (SlowTick) begin
						SerialData   <= ShiftReg[WordWidth-1]; // MSB first
						SerialStrobe <= 1'b1;
						BitCount     <= BitCount + 1'b1;      // Wraps at word end
						if (WordEnd) begin
							if (FifoEmpty)
								State <= ShFinish;
							else
								FifoReadEn <= 1'b1;
						end
					end
				end
				ShFinish: begin
					ConfigDone <= 1'b1; // One cycle after last strobe
					State      <= ShIdle;
				end
				default: State <= ShIdle;
			endcase
		end
	end

	// Word register, loaded alongside each pop
	always_ff @(posedge Clk) begin
		if (State == ShIdle && ParameterDone)
			ShiftReg <= FifoReadData;
		else if (State == ShShift && SlowTick)
			ShiftReg <= WordEnd ? FifoReadData : (ShiftReg << 1);
	end

endmodule

// File: list.f
MicrorocPkg.sv
ParameterFifo.sv
ParameterGenerator.sv
SerialShifter.sv
MicrorocConfigTop.sv
ConfigChecker.sv
ConfigTb.sv
